//--- run_sim.sh
#!/usr/bin/env bash
# builds the rv32 testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module rv32_tb -f tb.f -o rv32_sim

# a failed check ends the simulator with a non-zero status, the log decides
./obj_dir/rv32_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test completed successfully" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

//--- tb.f
+incdir+verilog
verilog/rv32_pkg.sv
verilog/rv32_hazard.sv
verilog/rv32_fetch.sv
verilog/rv32_decode.sv
verilog/rv32_execute.sv
verilog/rv32_mem.sv
verilog/rv32.sv
verification/rv32_properties.sv
verification/rv32_tb.sv

//--- verification/rv32_properties.sv
`default_nettype none

module rv32_properties (
    input logic clk,
    input logic reset,
    input logic branch_taken,
    input logic fetch_stall,
    input logic decode_stall,
    input logic fetch_flush,
    input logic decode_flush,
    input logic execute_flush
);
    timeunit 1ns;
    timeprecision 1ps;

    // a taken branch wins over a load-use stall
    no_stall_on_branch: assert property (@(posedge clk) disable iff (reset)
        branch_taken |-> !fetch_stall && !decode_stall)
        else $error("stall raised in the same cycle as a taken branch");

    flush_on_branch: assert property (@(posedge clk) disable iff (reset)
        branch_taken |-> fetch_flush && decode_flush && execute_flush)
        else $error("taken branch without a flush of fetch, decode and execute");

    flush_needs_branch: assert property (@(posedge clk) disable iff (reset)
        (fetch_flush || decode_flush || execute_flush) |-> branch_taken)
        else $error("flush raised without a taken branch");
endmodule

`default_nettype wire

//--- verification/rv32_tb.sv
`default_nettype none

module rv32_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int max_cycles = 5 * 120; // five tests of at most 120 cycles each
    localparam int run_cycles = 60;
    localparam logic [7:0] marker = 8'hee; // only ever written on a wrong path

    logic clk;
    logic reset;
    logic prog_we;
    logic [7:0] prog_addr;
    rv32_pkg::word_t prog_data;
    logic [7:0] leds;

    logic [31:0] lfsr_state = 32'he979;
    int cycle_count = 0;
    rv32_pkg::word_t prog[$]; // program of the current test
    logic [7:0] expected[$];
    logic [7:0] seen[$];

    rv32 dut0 (
        .clk(clk), .reset(reset), .prog_we(prog_we), .prog_addr(prog_addr),
        .prog_data(prog_data), .leds(leds)
    );

    bind rv32 rv32_properties props0 (
        .clk(clk), .reset(reset), .branch_taken(mem_branch_taken),
        .fetch_stall(fetch_stall), .decode_stall(decode_stall),
        .fetch_flush(fetch_flush), .decode_flush(decode_flush),
        .execute_flush(execute_flush)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= max_cycles) begin
            $display("timeout, the tests did not finish within %0d cycles", max_cycles);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
    endfunction

    function automatic logic [31:0] random_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]}; // one step per bit
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    function automatic rv32_pkg::word_t alu_reg(logic [6:0] f7, logic [2:0] f3,
            rv32_pkg::reg_addr_t rd, rv32_pkg::reg_addr_t rs1, rv32_pkg::reg_addr_t rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32_pkg::word_t alu_imm(logic [2:0] f3, rv32_pkg::reg_addr_t rd,
            rv32_pkg::reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic rv32_pkg::word_t upper_imm(rv32_pkg::reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic rv32_pkg::word_t load_word(rv32_pkg::reg_addr_t rd,
            rv32_pkg::reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic rv32_pkg::word_t store_word(rv32_pkg::reg_addr_t rs2,
            rv32_pkg::reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic rv32_pkg::word_t cond_branch(logic [2:0] f3, rv32_pkg::reg_addr_t rs1,
            rv32_pkg::reg_addr_t rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic rv32_pkg::word_t jump_link(rv32_pkg::reg_addr_t rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // op is {funct7[5], funct3} of the R-type instruction
    function automatic logic [31:0] alu_model(logic [3:0] op, logic [31:0] a, logic [31:0] b);
        case (op)
            4'b0000: return a + b;
            4'b1000: return a - b;
            4'b0001: return a << b[4:0];
            4'b0010: return {31'b0, $signed(a) < $signed(b)};
            4'b0011: return {31'b0, a < b};
            4'b0100: return a ^ b;
            4'b0101: return a >> b[4:0];
            4'b1101: return $signed(a) >>> b[4:0];
            4'b0110: return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check(string name, logic [31:0] actual, logic [31:0] want);
        if (actual !== want) begin
            $display("FAILED %s: got %h, expected %h", name, actual, want);
            $display("Test failed");
            $fatal(1, "check failed");
        end
    endtask

    // leds only changes when x31 gets a new low byte
    task automatic expect_leds(logic [31:0] x31_value);
        logic [7:0] last;
        last = (expected.size() == 0) ? 8'd0 : expected[expected.size() - 1];
        if (x31_value[7:0] != last)
            expected.push_back(x31_value[7:0]);
    endtask

    // lui plus addi where the upper part absorbs the sign of the low twelve bits
    task automatic put_const(rv32_pkg::reg_addr_t rd, logic [31:0] value);
        prog.push_back(upper_imm(rd, value[31:12] + {19'b0, value[11]}));
        prog.push_back(alu_imm(3'b000, rd, rd, value[11:0]));
    endtask

    task automatic run_program();
        logic [7:0] last;
        prog.push_back(jump_link(5'd0, 21'd0)); // park on a jump to itself
        reset = 1'b1;
        for (int i = 0; i < prog.size(); i++) begin
            prog_we = 1'b1;
            prog_addr = i[7:0];
            prog_data = prog[i];
            next_cycle();
        end
        prog_we = 1'b0;
        repeat (4) next_cycle();
        check("leds", {24'b0, leds}, 32'd0);
        reset = 1'b0;
        seen.delete();
        last = leds;
        repeat (run_cycles) begin
            next_cycle();
            if (leds != last) begin
                seen.push_back(leds);
                last = leds;
            end
        end
        check("leds change count", seen.size(), expected.size());
        for (int i = 0; i < expected.size(); i++)
            check("leds", {24'b0, seen[i]}, {24'b0, expected[i]});
    endtask

    task automatic alu_test();
        logic [31:0] ra;
        logic [31:0] rb;
        logic [31:0] a;
        logic [31:0] b;
        logic [3:0] ops [10];
        ops = '{4'b0000, 4'b1000, 4'b0111, 4'b0110, 4'b0100,
                4'b0010, 4'b0011, 4'b0001, 4'b0101, 4'b1101};
        prog.delete();
        expected.delete();
        ra = random_bits(12);
        rb = random_bits(12);
        a = {{20{ra[11]}}, ra[11:0]};
        b = {{20{rb[11]}}, rb[11:0]};
        prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, ra[11:0]));
        prog.push_back(alu_imm(3'b000, 5'd2, 5'd0, rb[11:0]));
        for (int i = 0; i < 10; i++) begin
            prog.push_back(alu_reg({1'b0, ops[i][3], 5'b0}, ops[i][2:0], 5'd3, 5'd1, 5'd2));
            prog.push_back(alu_imm(3'b000, 5'd31, 5'd3, 12'd0)); // mv x31, x3
            expect_leds(alu_model(ops[i], a, b));
        end
        run_program();
    endtask

    // each register is the sum of the two before it
    task automatic forwarding_test();
        logic [31:0] r;
        logic [31:0] v [1:8];
        prog.delete();
        expected.delete();
        for (int k = 1; k <= 2; k++) begin
            r = random_bits(12);
            v[k] = {{20{r[11]}}, r[11:0]};
            prog.push_back(alu_imm(3'b000, k[4:0], 5'd0, r[11:0]));
        end
        for (int k = 3; k <= 8; k++) begin
            v[k] = v[k - 1] + v[k - 2];
            prog.push_back(alu_reg(7'd0, 3'b000, k[4:0], k[4:0] - 5'd1, k[4:0] - 5'd2));
        end
        prog.push_back(alu_reg(7'd0, 3'b000, 5'd31, 5'd8, 5'd7));
        prog.push_back(alu_reg(7'd0, 3'b000, 5'd31, 5'd31, 5'd6));
        expect_leds(v[8] + v[7]);
        expect_leds(v[8] + v[7] + v[6]);
        run_program();
    endtask

    task automatic load_use_test();
        logic [31:0] w;
        logic [31:0] v;
        logic [31:0] addr;
        prog.delete();
        expected.delete();
        w = random_bits(32);
        v = random_bits(32);
        addr = random_bits(8) << 2; // any word of the data memory
        put_const(5'd6, w);
        put_const(5'd7, v);
        prog.push_back(alu_imm(3'b000, 5'd8, 5'd0, addr[11:0]));
        prog.push_back(store_word(5'd6, 5'd8, 12'd0));
        prog.push_back(load_word(5'd5, 5'd8, 12'd0));
        prog.push_back(alu_reg(7'd0, 3'b000, 5'd31, 5'd5, 5'd7)); // load used on rs1
        prog.push_back(load_word(5'd9, 5'd8, 12'd0));
        prog.push_back(alu_reg(7'b0100000, 3'b000, 5'd31, 5'd7, 5'd9)); // and on rs2
        expect_leds(w + v);
        expect_leds(v - w);
        run_program();
    endtask

    task automatic branch_test();
        prog.delete();
        expected.delete();
        prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, 12'd5));
        prog.push_back(alu_imm(3'b000, 5'd2, 5'd0, 12'd5));
        prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, 12'h011));
        prog.push_back(cond_branch(3'b000, 5'd1, 5'd2, 13'd16)); // taken beq
        repeat (3) prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, {4'b0, marker}));
        prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, 12'h022));
        prog.push_back(cond_branch(3'b001, 5'd1, 5'd2, 13'd16)); // untaken bne
        prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, 12'h033));
        prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, 12'h044));
        prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, 12'h055));
        prog.push_back(jump_link(5'd1, 21'd16)); // jal at word 12 links 52
        repeat (3) prog.push_back(alu_imm(3'b000, 5'd31, 5'd0, {4'b0, marker}));
        prog.push_back(alu_reg(7'd0, 3'b000, 5'd31, 5'd1, 5'd0));
        expect_leds(32'h11);
        expect_leds(32'h22);
        expect_leds(32'h33);
        expect_leds(32'h44);
        expect_leds(32'h55);
        expect_leds(32'd13 * 32'd4);
        run_program();
    endtask

    task automatic reset_test();
        prog.delete();
        expected.delete();
        prog.push_back(alu_imm(3'b000, 5'd1, 5'd0, 12'h05a));
        prog.push_back(alu_imm(3'b000, 5'd0, 5'd0, 12'h07f)); // lost because x0 stays zero
        prog.push_back(alu_reg(7'd0, 3'b000, 5'd30, 5'd1, 5'd1));
        prog.push_back(upper_imm(5'd29, 20'habcde));
        prog.push_back(alu_reg(7'd0, 3'b000, 5'd31, 5'd0, 5'd0));
        run_program();
    endtask

    initial begin
        reset = 1'b1;
        prog_we = 1'b0;
        prog_addr = 8'd0;
        prog_data = '0;
        repeat (4) next_cycle();
        alu_test();
        forwarding_test();
        load_use_test();
        branch_test();
        reset_test();
        $display("Test completed successfully");
        $finish;
    end
endmodule

`default_nettype wire

//--- verilog/rv32.sv
`default_nettype none

module rv32 (
    input  logic            clk,
    input  logic            reset,
    input  logic            prog_we,
    input  logic [7:0]      prog_addr,
    input  rv32_pkg::word_t prog_data,
    output logic [7:0]      leds
);
    logic fetch_stall;
    logic fetch_flush;
    logic decode_stall;
    logic decode_flush;
    logic execute_flush;

    rv32_pkg::word_t fetch_pc;
    rv32_pkg::word_t fetch_instr;

    rv32_pkg::reg_addr_t decode_rs1_unreg; // to hazard
    rv32_pkg::reg_addr_t decode_rs2_unreg;
    rv32_pkg::reg_addr_t decode_rs1;
    rv32_pkg::reg_addr_t decode_rs2;
    rv32_pkg::reg_addr_t decode_rd;
    rv32_pkg::alu_op_t decode_alu_op;
    logic decode_alu_src1;
    logic decode_alu_src2;
    logic decode_mem_read_en;
    logic decode_mem_write_en;
    rv32_pkg::branch_op_t decode_branch_op;
    logic decode_rd_writeback;
    rv32_pkg::word_t decode_pc;
    rv32_pkg::word_t decode_rs1_value;
    rv32_pkg::word_t decode_rs2_value;
    rv32_pkg::word_t decode_imm;

    logic execute_mem_read_en;
    logic execute_mem_write_en;
    rv32_pkg::branch_op_t execute_branch_op;
    logic execute_branch_cond;
    rv32_pkg::reg_addr_t execute_rd;
    logic execute_rd_writeback;
    rv32_pkg::word_t execute_result;
    rv32_pkg::word_t execute_rs2_value;
    rv32_pkg::word_t execute_branch_pc;

    logic mem_branch_taken;
    rv32_pkg::reg_addr_t mem_rd; // writeback triple
    logic mem_rd_writeback;
    rv32_pkg::word_t mem_rd_value;
    rv32_pkg::word_t mem_branch_pc;

    always_ff @(posedge clk) begin
        if (reset)
            leds <= 8'd0;
        else if (mem_rd_writeback && mem_rd == 5'd31)
            leds <= mem_rd_value[7:0];
    end

    rv32_hazard hazard (
        .decode_rs1(decode_rs1_unreg), .decode_rs2(decode_rs2_unreg),
        .decode_rd(decode_rd),
        .decode_mem_read_en(decode_mem_read_en),
        .decode_rd_writeback(decode_rd_writeback),
        .branch_taken(mem_branch_taken),
        .fetch_stall(fetch_stall), .fetch_flush(fetch_flush),
        .decode_stall(decode_stall), .decode_flush(decode_flush),
        .execute_flush(execute_flush)
    );

    rv32_fetch fetch (
        .clk(clk), .reset(reset), .stall(fetch_stall), .flush(fetch_flush),
        .branch_taken(mem_branch_taken), .branch_pc(mem_branch_pc),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .pc(fetch_pc), .instr(fetch_instr)
    );

    rv32_decode decode (
        .clk(clk), .reset(reset), .stall(decode_stall), .flush(decode_flush),
        .rd_in(mem_rd), .rd_writeback_in(mem_rd_writeback), .rd_value_in(mem_rd_value),
        .pc_in(fetch_pc), .instr_in(fetch_instr),
        .rs1_unreg(decode_rs1_unreg), .rs2_unreg(decode_rs2_unreg),
        .rs1(decode_rs1), .rs2(decode_rs2), .rd(decode_rd),
        .alu_op(decode_alu_op), .alu_src1(decode_alu_src1), .alu_src2(decode_alu_src2),
        .mem_read_en(decode_mem_read_en), .mem_write_en(decode_mem_write_en),
        .branch_op(decode_branch_op), .rd_writeback(decode_rd_writeback),
        .pc(decode_pc), .rs1_value(decode_rs1_value), .rs2_value(decode_rs2_value),
        .imm(decode_imm)
    );

    rv32_execute execute (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(execute_flush),
        .rs1_in(decode_rs1), .rs2_in(decode_rs2), .rd_in(decode_rd),
        .alu_op_in(decode_alu_op), .alu_src1_in(decode_alu_src1),
        .alu_src2_in(decode_alu_src2),
        .mem_read_en_in(decode_mem_read_en), .mem_write_en_in(decode_mem_write_en),
        .branch_op_in(decode_branch_op), .rd_writeback_in(decode_rd_writeback),
        .pc_in(decode_pc), .rs1_value_in(decode_rs1_value),
        .rs2_value_in(decode_rs2_value), .imm_in(decode_imm),
        .writeback_rd(mem_rd), .writeback_rd_writeback(mem_rd_writeback),
        .writeback_rd_value(mem_rd_value),
        .mem_read_en(execute_mem_read_en), .mem_write_en(execute_mem_write_en),
        .branch_op(execute_branch_op), .branch_cond(execute_branch_cond),
        .rd(execute_rd), .rd_writeback(execute_rd_writeback),
        .result(execute_result), .rs2_value(execute_rs2_value),
        .branch_pc(execute_branch_pc)
    );

    rv32_mem mem (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0),
        .read_en(execute_mem_read_en), .write_en(execute_mem_write_en),
        .branch_op(execute_branch_op), .branch_cond(execute_branch_cond),
        .rd_in(execute_rd), .rd_writeback_in(execute_rd_writeback),
        .result(execute_result), .rs2_value(execute_rs2_value),
        .branch_pc_in(execute_branch_pc),
        .branch_taken(mem_branch_taken), .rd(mem_rd),
        .rd_writeback(mem_rd_writeback), .rd_value(mem_rd_value),
        .branch_pc(mem_branch_pc)
    );
endmodule

`default_nettype wire

//--- verilog/rv32_decode.sv
`default_nettype none

module rv32_decode (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  rv32_pkg::reg_addr_t  rd_in,
    input  logic                 rd_writeback_in,
    input  rv32_pkg::word_t      rd_value_in,
    input  rv32_pkg::word_t      pc_in,
    input  rv32_pkg::word_t      instr_in,
    output rv32_pkg::reg_addr_t  rs1_unreg,
    output rv32_pkg::reg_addr_t  rs2_unreg,
    output rv32_pkg::reg_addr_t  rs1,
    output rv32_pkg::reg_addr_t  rs2,
    output rv32_pkg::reg_addr_t  rd,
    output rv32_pkg::alu_op_t    alu_op,
    output logic                 alu_src1,
    output logic                 alu_src2,
    output logic                 mem_read_en,
    output logic                 mem_write_en,
    output rv32_pkg::branch_op_t branch_op,
    output logic                 rd_writeback,
    output rv32_pkg::word_t      pc,
    output rv32_pkg::word_t      rs1_value,
    output rv32_pkg::word_t      rs2_value,
    output rv32_pkg::word_t      imm
);
    rv32_pkg::word_t regs [1:31]; // x0 is not stored
    logic [6:0] opcode;
    logic [2:0] funct3;
    rv32_pkg::alu_op_t alu_op_d;
    logic alu_src1_d;
    logic alu_src2_d;
    logic read_d;
    logic write_d;
    rv32_pkg::branch_op_t branch_d;
    logic writeback_d;
    rv32_pkg::word_t imm_d;

    function automatic rv32_pkg::word_t read_reg(rv32_pkg::reg_addr_t r);
        if (r == 5'd0)
            return '0;
        if (rd_writeback_in && rd_in == r)
            return rd_value_in; // value written back this cycle
        return regs[r];
    endfunction

    assign opcode = instr_in[6:0];
    assign funct3 = instr_in[14:12];
    assign rs1_unreg = instr_in[19:15];
    assign rs2_unreg = instr_in[24:20];

    always_comb begin
        alu_op_d = rv32_pkg::alu_add;
        alu_src1_d = 1'b0;
        alu_src2_d = 1'b1;
        read_d = 1'b0;
        write_d = 1'b0;
        branch_d = rv32_pkg::branch_none;
        writeback_d = 1'b0;
        imm_d = {{20{instr_in[31]}}, instr_in[31:20]}; // I-type
        case (opcode)
            7'b0110011: begin // register-register
                alu_op_d = {instr_in[30], funct3};
                alu_src2_d = 1'b0;
                writeback_d = 1'b1;
            end
            7'b0010011: begin // register-immediate, funct7 only matters for srai
                alu_op_d = {funct3 == 3'b101 && instr_in[30], funct3};
                writeback_d = 1'b1;
            end
            7'b0110111: begin // lui
                alu_op_d = rv32_pkg::alu_pass_imm;
                imm_d = {instr_in[31:12], 12'b0};
                writeback_d = 1'b1;
            end
            7'b0000011: begin // lw
                read_d = 1'b1;
                writeback_d = 1'b1;
            end
            7'b0100011: begin // sw
                write_d = 1'b1;
                imm_d = {{20{instr_in[31]}}, instr_in[31:25], instr_in[11:7]};
            end
            7'b1100011: begin
                alu_src2_d = 1'b0;
                branch_d = funct3[0] ? rv32_pkg::branch_bne : rv32_pkg::branch_beq;
                imm_d = {{19{instr_in[31]}}, instr_in[31], instr_in[7],
                         instr_in[30:25], instr_in[11:8], 1'b0};
            end
            7'b1101111: begin // jal, link address comes from the ALU
                alu_src1_d = 1'b1;
                branch_d = rv32_pkg::branch_jump;
                writeback_d = 1'b1;
                imm_d = {{11{instr_in[31]}}, instr_in[31], instr_in[19:12],
                         instr_in[20], instr_in[30:21], 1'b0};
            end
            default: ; // unsupported, passes as a bubble
        endcase
    end

    always_ff @(posedge clk) begin
        if (rd_writeback_in && rd_in != 5'd0)
            regs[rd_in] <= rd_value_in;
    end

    // a stall leaves the instruction in fetch, so a bubble goes down the pipe
    always_ff @(posedge clk) begin
        if (reset || stall || flush) begin
            mem_read_en <= 1'b0;
            mem_write_en <= 1'b0;
            rd_writeback <= 1'b0;
            branch_op <= rv32_pkg::branch_none;
        end else begin
            mem_read_en <= read_d;
            mem_write_en <= write_d;
            rd_writeback <= writeback_d;
            branch_op <= branch_d;
        end
    end

    always_ff @(posedge clk) begin
        rs1 <= rs1_unreg;
        rs2 <= rs2_unreg;
        rd <= instr_in[11:7];
        alu_op <= alu_op_d;
        alu_src1 <= alu_src1_d;
        alu_src2 <= alu_src2_d;
        pc <= pc_in;
        rs1_value <= read_reg(rs1_unreg);
        rs2_value <= read_reg(rs2_unreg);
        imm <= imm_d;
    end
endmodule

`default_nettype wire

//--- verilog/rv32_execute.sv
`default_nettype none

module rv32_execute (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  rv32_pkg::reg_addr_t  rs1_in,
    input  rv32_pkg::reg_addr_t  rs2_in,
    input  rv32_pkg::reg_addr_t  rd_in,
    input  rv32_pkg::alu_op_t    alu_op_in,
    input  logic                 alu_src1_in,
    input  logic                 alu_src2_in,
    input  logic                 mem_read_en_in,
    input  logic                 mem_write_en_in,
    input  rv32_pkg::branch_op_t branch_op_in,
    input  logic                 rd_writeback_in,
    input  rv32_pkg::word_t      pc_in,
    input  rv32_pkg::word_t      rs1_value_in,
    input  rv32_pkg::word_t      rs2_value_in,
    input  rv32_pkg::word_t      imm_in,
    input  rv32_pkg::reg_addr_t  writeback_rd,
    input  logic                 writeback_rd_writeback,
    input  rv32_pkg::word_t      writeback_rd_value,
    output logic                 mem_read_en,
    output logic                 mem_write_en,
    output rv32_pkg::branch_op_t branch_op,
    output logic                 branch_cond,
    output rv32_pkg::reg_addr_t  rd,
    output logic                 rd_writeback,
    output rv32_pkg::word_t      result,
    output rv32_pkg::word_t      rs2_value,
    output rv32_pkg::word_t      branch_pc
);
    rv32_pkg::word_t src1; // rs1 after forwarding
    rv32_pkg::word_t src2;
    rv32_pkg::word_t op1;
    rv32_pkg::word_t op2;
    rv32_pkg::word_t alu_out;

    // newest value wins; a load in our own register is not ready yet
    function automatic rv32_pkg::word_t forward(rv32_pkg::reg_addr_t r,
                                                rv32_pkg::word_t v);
        if (r != 5'd0 && rd_writeback && !mem_read_en && rd == r)
            return result;
        if (r != 5'd0 && writeback_rd_writeback && writeback_rd == r)
            return writeback_rd_value;
        return v;
    endfunction

    always_comb begin
        src1 = forward(rs1_in, rs1_value_in);
        src2 = forward(rs2_in, rs2_value_in);
        op1 = alu_src1_in ? pc_in : src1;
        op2 = alu_src1_in ? 32'd4 : (alu_src2_in ? imm_in : src2); // jal links pc + 4
        case (alu_op_in)
            rv32_pkg::alu_sub:      alu_out = op1 - op2;
            rv32_pkg::alu_sll:      alu_out = op1 << op2[4:0];
            rv32_pkg::alu_slt:      alu_out = {31'b0, $signed(op1) < $signed(op2)};
            rv32_pkg::alu_sltu:     alu_out = {31'b0, op1 < op2};
            rv32_pkg::alu_xor:      alu_out = op1 ^ op2;
            rv32_pkg::alu_srl:      alu_out = op1 >> op2[4:0];
            rv32_pkg::alu_sra:      alu_out = $signed(op1) >>> op2[4:0];
            rv32_pkg::alu_or:       alu_out = op1 | op2;
            rv32_pkg::alu_and:      alu_out = op1 & op2;
            rv32_pkg::alu_pass_imm: alu_out = op2;
            default:                alu_out = op1 + op2; // add, also address calculation
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            mem_read_en <= 1'b0;
            mem_write_en <= 1'b0;
            rd_writeback <= 1'b0;
            branch_op <= rv32_pkg::branch_none;
        end else if (!stall) begin
            mem_read_en <= mem_read_en_in;
            mem_write_en <= mem_write_en_in;
            rd_writeback <= rd_writeback_in;
            branch_op <= branch_op_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            branch_cond <= src1 == src2;
            rd <= rd_in;
            result <= alu_out;
            rs2_value <= src2; // store data
            branch_pc <= pc_in + imm_in;
        end
    end
endmodule

`default_nettype wire

//--- verilog/rv32_fetch.sv
`include "rv32_settings.svh"
`default_nettype none

module rv32_fetch (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic            flush,
    input  logic            branch_taken,
    input  rv32_pkg::word_t branch_pc,
    input  logic            prog_we,
    input  logic [7:0]      prog_addr,
    input  rv32_pkg::word_t prog_data,
    output rv32_pkg::word_t pc,
    output rv32_pkg::word_t instr
);
    localparam int imem_bits = $clog2(`RV32_IMEM_WORDS);
    localparam rv32_pkg::word_t nop = 32'h0000_0013; // addi x0, x0, 0

    rv32_pkg::word_t imem [`RV32_IMEM_WORDS];
    rv32_pkg::word_t next_pc; // address of the word read on the next edge

    always_ff @(posedge clk) begin
        if (prog_we)
            imem[prog_addr] <= prog_data; // loader, used while reset is held
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            next_pc <= `RV32_RESET_PC;
            pc <= `RV32_RESET_PC;
            instr <= nop;
        end else if (!stall) begin
            pc <= next_pc;
            instr <= flush ? nop : imem[next_pc[imem_bits+1:2]];
            next_pc <= branch_taken ? branch_pc : next_pc + 32'd4;
        end
    end
endmodule

`default_nettype wire

//--- verilog/rv32_hazard.sv
`default_nettype none

module rv32_hazard (
    input  rv32_pkg::reg_addr_t decode_rs1,
    input  rv32_pkg::reg_addr_t decode_rs2,
    input  rv32_pkg::reg_addr_t decode_rd,
    input  logic                decode_mem_read_en,
    input  logic                decode_rd_writeback,
    input  logic                branch_taken,
    output logic                fetch_stall,
    output logic                fetch_flush,
    output logic                decode_stall,
    output logic                decode_flush,
    output logic                execute_flush
);
    logic load_use; // load in execute feeds the instruction being decoded

    assign load_use = decode_mem_read_en && decode_rd_writeback && decode_rd != 5'd0
                      && (decode_rd == decode_rs1 || decode_rd == decode_rs2);

    // the wrong-path load does not matter once a branch is taken
    assign fetch_stall = load_use && !branch_taken;
    assign decode_stall = fetch_stall;

    assign fetch_flush = branch_taken;
    assign decode_flush = branch_taken;
    assign execute_flush = branch_taken;
endmodule

`default_nettype wire

//--- verilog/rv32_mem.sv
`include "rv32_settings.svh"
`default_nettype none

module rv32_mem (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 stall,
    input  logic                 flush,
    input  logic                 read_en,
    input  logic                 write_en,
    input  rv32_pkg::branch_op_t branch_op,
    input  logic                 branch_cond,
    input  rv32_pkg::reg_addr_t  rd_in,
    input  logic                 rd_writeback_in,
    input  rv32_pkg::word_t      result,
    input  rv32_pkg::word_t      rs2_value,
    input  rv32_pkg::word_t      branch_pc_in,
    output logic                 branch_taken,
    output rv32_pkg::reg_addr_t  rd,
    output logic                 rd_writeback,
    output rv32_pkg::word_t      rd_value,
    output rv32_pkg::word_t      branch_pc
);
    localparam int dmem_bits = $clog2(`RV32_DMEM_WORDS);

    rv32_pkg::word_t dmem [`RV32_DMEM_WORDS];
    logic [dmem_bits-1:0] addr; // word address
    logic kill;
    logic taken;

    // the instruction behind a taken branch is already in execute's register
    assign kill = flush || branch_taken;
    assign addr = result[dmem_bits+1:2];

    always_comb begin
        case (branch_op)
            rv32_pkg::branch_beq:  taken = branch_cond;
            rv32_pkg::branch_bne:  taken = !branch_cond;
            rv32_pkg::branch_jump: taken = 1'b1;
            default:               taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (write_en && !kill)
                dmem[addr] <= rs2_value;
            rd_value <= read_en ? dmem[addr] : result;
            rd <= rd_in;
            branch_pc <= branch_pc_in;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_taken <= 1'b0;
            rd_writeback <= 1'b0;
        end else if (!stall) begin
            branch_taken <= taken && !kill;
            rd_writeback <= rd_writeback_in && !kill;
        end
    end
endmodule

`default_nettype wire

//--- verilog/rv32_pkg.sv
`default_nettype none

package rv32_pkg;
    typedef logic [31:0] word_t;     // data, address or instruction
    typedef logic [4:0]  reg_addr_t; // register number
    typedef logic [3:0]  alu_op_t;
    typedef logic [1:0]  branch_op_t;

    // ALU codes follow {funct7[5], funct3} of the R-type encoding
    localparam alu_op_t alu_add      = 4'b0000;
    localparam alu_op_t alu_sub      = 4'b1000;
    localparam alu_op_t alu_sll      = 4'b0001;
    localparam alu_op_t alu_slt      = 4'b0010;
    localparam alu_op_t alu_sltu     = 4'b0011;
    localparam alu_op_t alu_xor      = 4'b0100;
    localparam alu_op_t alu_srl      = 4'b0101;
    localparam alu_op_t alu_sra      = 4'b1101;
    localparam alu_op_t alu_or       = 4'b0110;
    localparam alu_op_t alu_and      = 4'b0111;
    localparam alu_op_t alu_pass_imm = 4'b1111; // lui

    localparam branch_op_t branch_none = 2'd0;
    localparam branch_op_t branch_beq  = 2'd1;
    localparam branch_op_t branch_bne  = 2'd2;
    localparam branch_op_t branch_jump = 2'd3; // jal, always taken
endpackage

`default_nettype wire

//--- verilog/rv32_settings.svh
`ifndef RV32_SETTINGS_SVH
`define RV32_SETTINGS_SVH

// instruction memory depth in words
`define RV32_IMEM_WORDS 256

`define RV32_DMEM_WORDS 256 // data memory depth in words

`define RV32_RESET_PC 32'h0000_0000 // first fetch address

`endif
